/* common/fft_consts.svh */
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// Transform geometry
`define FFT_POINTS   8
`define FFT_STAGES   3
`define FFT_LANES    4

// Fixed point formats
`define SAMPLE_WIDTH 16
`define TWIDDLE_FRAC 14

// Forward twiddles W^k in Q1.14
`define TW_RE0 16'sd16384
`define TW_IM0 16'sd0
`define TW_RE1 16'sd11585
`define TW_IM1 (-16'sd11585)
`define TW_RE2 16'sd0
`define TW_IM2 (-16'sd16384)
`define TW_RE3 (-16'sd11585)
`define TW_IM3 (-16'sd11585)

`endif

/* common/fftTypes.sv */
`include "fft_consts.svh"

package fftTypes;

    ////////////////////
    // Scalars
    ////////////////////

    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [$clog2(`FFT_POINTS)-1:0] addr_t;
    typedef logic [$clog2(`FFT_STAGES)-1:0] stage_t;

    ////////////////////
    // Bundles
    ////////////////////

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // Operands for one butterfly lane
    typedef struct packed {
        cplx_t a;
        cplx_t b;
        cplx_t w;
        addr_t addrA;
        addr_t addrB;
        logic  valid;
    } bflyOp_t;

    // x goes back to addrA, y to addrB
    typedef struct packed {
        cplx_t x;
        cplx_t y;
        addr_t addrA;
        addr_t addrB;
        logic  valid;
    } bflyRes_t;

    typedef enum logic [3:0] {
        IDLE,
        IDLE_LOADF,
        IDLE_LOADI,
        LOADF,
        LOADI,
        CALCULATINGF,
        CALCULATINGI,
        LOADOUT,
        DONE
    } ctrlState_t;

endpackage

/* control/fftControl.sv */
`timescale 1ns/1ns

module fftControl (
    input  logic clk,
    input  logic rst,
    input  logic startF,
    input  logic startI,
    input  logic startLoadingRam,
    input  logic loadExternalDone,
    input  logic done,
    input  logic outDone,
    input  logic transformComplete,
    output logic calculating,
    output logic loadExternal,
    output logic loadInternal,
    output logic isIFFT,
    output logic aDone,
    output logic loadOutBuffer
);

    import fftTypes::*;

    ctrlState_t state;
    ctrlState_t nextState;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////
    // Next state and outputs
    ////////////////////

    always_comb begin
        nextState = state;
        calculating = 1'b0;
        loadExternal = 1'b0;
        loadInternal = 1'b0;
        isIFFT = 1'b0;
        aDone = 1'b0;
        loadOutBuffer = 1'b0;

        case (state)
            IDLE: begin
                if (startF) begin
                    nextState = IDLE_LOADF;
                end else if (startI) begin
                    nextState = IDLE_LOADI;
                end
            end

            // Wait for the host to begin streaming
            IDLE_LOADF: begin
                calculating = 1'b1;
                loadExternal = startLoadingRam;
                if (startLoadingRam) begin
                    nextState = LOADF;
                end
            end

            IDLE_LOADI: begin
                calculating = 1'b1;
                loadExternal = startLoadingRam;
                if (startLoadingRam) begin
                    nextState = LOADI;
                end
            end

            LOADF: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (loadExternalDone) begin
                    nextState = CALCULATINGF;
                end
            end

            LOADI: begin
                calculating = 1'b1;
                loadExternal = 1'b1;
                if (loadExternalDone) begin
                    nextState = CALCULATINGI;
                end
            end

            // Butterfly stages
            CALCULATINGF: begin
                calculating = 1'b1;
                if (done) begin
                    nextState = LOADOUT;
                end else begin
                    loadInternal = 1'b1;
                end
            end

            CALCULATINGI: begin
                calculating = 1'b1;
                isIFFT = 1'b1;
                if (done) begin
                    nextState = LOADOUT;
                end else begin
                    loadInternal = 1'b1;
                end
            end

            LOADOUT: begin
                calculating = 1'b1;
                if (outDone) begin
                    nextState = DONE;
                end else begin
                    loadOutBuffer = 1'b1;
                end
            end

            DONE: begin
                calculating = 1'b1;
                aDone = 1'b1;
                if (transformComplete) begin
                    nextState = IDLE;
                end
            end

            default: nextState = IDLE;
        endcase
    end

    // Host never requests both directions at once
    assert property (@(posedge clk) disable iff (rst) !(startF && startI))
        else $error("startF and startI high together");

    // Last stage only retires during the compute phase
    assert property (@(posedge clk) disable iff (rst)
        done |-> state == CALCULATINGF || state == CALCULATINGI)
        else $error("done outside the compute phase");

endmodule

/* logic/sampleRam.sv */
`timescale 1ns/1ns
`include "fft_consts.svh"

module sampleRam (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             loadExternal,
    input  logic                             loadOutBuffer,
    input  logic                             sampleValid,
    input  fftTypes::cplx_t                  sampleIn,
    input  logic [`FFT_POINTS-1:0]           wrEn,
    input  fftTypes::cplx_t [`FFT_POINTS-1:0] wrData,
    output logic                             loadExternalDone,
    output fftTypes::cplx_t [`FFT_POINTS-1:0] words,
    output logic                             outValid,
    output fftTypes::cplx_t                  outSample,
    output logic                             outDone
);

    import fftTypes::*;

    localparam addr_t LastAddr = addr_t'(`FFT_POINTS - 1);

    cplx_t [`FFT_POINTS-1:0] mem;
    addr_t loadCnt;
    addr_t outCnt;
    logic  accept;

    function automatic addr_t bitReverse(input addr_t a);
        addr_t r;
        for (int i = 0; i < $bits(addr_t); i++) begin
            r[i] = a[$bits(addr_t)-1-i];
        end
        return r;
    endfunction

    assign accept = loadExternal && sampleValid;
    assign words = mem;

    // Loader has priority; the two never overlap
    always_ff @(posedge clk) begin
        for (int i = 0; i < `FFT_POINTS; i++) begin
            if (accept && bitReverse(loadCnt) == addr_t'(i)) begin
                mem[i] <= sampleIn;
            end else if (wrEn[i]) begin
                mem[i] <= wrData[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loadCnt <= '0;
            outCnt <= '0;
            loadExternalDone <= 1'b0;
            outValid <= 1'b0;
            outDone <= 1'b0;
        end else begin
            loadExternalDone <= accept && loadCnt == LastAddr;
            if (!loadExternal) begin
                loadCnt <= '0;
            end else if (accept) begin
                loadCnt <= loadCnt + 1'b1;
            end
            outValid <= loadOutBuffer;
            outDone <= loadOutBuffer && outCnt == LastAddr;
            outCnt <= loadOutBuffer ? outCnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (loadOutBuffer) begin
            outSample <= mem[outCnt];
        end
    end

    assert property (@(posedge clk) disable iff (rst) loadExternal |-> wrEn == '0)
        else $error("Write-back during external load");

endmodule

/* butterfly/stageFeeder.sv */
`timescale 1ns/1ns
`include "fft_consts.svh"

module stageFeeder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               loadInternal,
    input  logic                               isIFFT,
    input  logic                               stageWritten,
    input  fftTypes::cplx_t [`FFT_POINTS-1:0]  words,
    output fftTypes::bflyOp_t [`FFT_LANES-1:0] ops,
    output fftTypes::stage_t                   stage
);

    import fftTypes::*;

    localparam stage_t LastStage = stage_t'(`FFT_STAGES - 1);

    bflyOp_t [`FFT_LANES-1:0] nextOps;
    bflyOp_t [`FFT_LANES-1:0] opsQ;
    logic pending;
    logic opValid;
    logic issue;

    function automatic cplx_t twiddle(input logic [1:0] k, input logic conj);
        cplx_t w;
        case (k)
            2'd0: w = '{re: `TW_RE0, im: `TW_IM0};
            2'd1: w = '{re: `TW_RE1, im: `TW_IM1};
            2'd2: w = '{re: `TW_RE2, im: `TW_IM2};
            default: w = '{re: `TW_RE3, im: `TW_IM3};
        endcase
        if (conj) begin
            w.im = -w.im;
        end
        return w;
    endfunction

    ////////////////////
    // Operand selection
    ////////////////////

    always_comb begin
        int span;
        int grp;
        int pos;
        int idxA;
        logic [1:0] twIdx;
        span = 1 << stage;
        for (int l = 0; l < `FFT_LANES; l++) begin
            grp = l >> stage;
            pos = l & (span - 1);
            idxA = grp * 2 * span + pos;
            twIdx = 2'((pos * (`FFT_POINTS / 2)) >> stage);
            nextOps[l].a = words[idxA];
            nextOps[l].b = words[idxA + span];
            nextOps[l].w = twiddle(twIdx, isIFFT);
            nextOps[l].addrA = addr_t'(idxA);
            nextOps[l].addrB = addr_t'(idxA + span);
            nextOps[l].valid = 1'b1;
        end
    end

    // One stage in flight at a time
    assign issue = loadInternal && !pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            opValid <= 1'b0;
            stage <= '0;
        end else begin
            opValid <= issue;
            if (issue) begin
                pending <= 1'b1;
            end else if (stageWritten) begin
                pending <= 1'b0;
            end
            if (stageWritten) begin
                stage <= (stage == LastStage) ? '0 : stage + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            opsQ <= nextOps;
        end
    end

    always_comb begin
        for (int l = 0; l < `FFT_LANES; l++) begin
            ops[l] = opsQ[l];
            ops[l].valid = opValid;
        end
    end

endmodule

/* butterfly/butterflyUnit.sv */
`timescale 1ns/1ns
`include "fft_consts.svh"

module butterflyUnit (
    input  logic               clk,
    input  logic               rst,
    input  fftTypes::bflyOp_t  op,
    output fftTypes::bflyRes_t res
);

    import fftTypes::*;

    localparam int ProdWidth = 2 * `SAMPLE_WIDTH + 1;
    localparam int TermWidth = ProdWidth - `TWIDDLE_FRAC;
    localparam int SumWidth = TermWidth + 1;

    logic signed [ProdWidth-1:0] prodRe;
    logic signed [ProdWidth-1:0] prodIm;
    logic signed [TermWidth-1:0] tRe;
    logic signed [TermWidth-1:0] tIm;
    logic signed [SumWidth-1:0] sumRe;
    logic signed [SumWidth-1:0] sumIm;
    logic signed [SumWidth-1:0] difRe;
    logic signed [SumWidth-1:0] difIm;
    logic  resValid;
    cplx_t xQ;
    cplx_t yQ;
    addr_t addrAQ;
    addr_t addrBQ;

    // t = b * w, truncated back to sample scale
    always_comb begin
        prodRe = $signed(op.b.re) * $signed(op.w.re) - $signed(op.b.im) * $signed(op.w.im);
        prodIm = $signed(op.b.re) * $signed(op.w.im) + $signed(op.b.im) * $signed(op.w.re);
        tRe = prodRe[ProdWidth-1:`TWIDDLE_FRAC];
        tIm = prodIm[ProdWidth-1:`TWIDDLE_FRAC];
        sumRe = $signed(op.a.re) + tRe;
        sumIm = $signed(op.a.im) + tIm;
        difRe = $signed(op.a.re) - tRe;
        difIm = $signed(op.a.im) - tIm;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= op.valid;
        end
    end

    // Halved outputs, bit 0 dropped
    always_ff @(posedge clk) begin
        xQ <= '{re: sumRe[`SAMPLE_WIDTH:1], im: sumIm[`SAMPLE_WIDTH:1]};
        yQ <= '{re: difRe[`SAMPLE_WIDTH:1], im: difIm[`SAMPLE_WIDTH:1]};
        addrAQ <= op.addrA;
        addrBQ <= op.addrB;
    end

    assign res = '{x: xQ, y: yQ, addrA: addrAQ, addrB: addrBQ, valid: resValid};

endmodule

/* butterfly/stageCollector.sv */
`timescale 1ns/1ns
`include "fft_consts.svh"

module stageCollector (
    input  logic                                clk,
    input  logic                                rst,
    input  fftTypes::bflyRes_t [`FFT_LANES-1:0] res,
    input  fftTypes::stage_t                    stage,
    output logic [`FFT_POINTS-1:0]              wrEn,
    output fftTypes::cplx_t [`FFT_POINTS-1:0]   wrData,
    output logic                                stageWritten,
    output logic                                done
);

    import fftTypes::*;

    localparam stage_t LastStage = stage_t'(`FFT_STAGES - 1);

    stage_t stagesDone;
    logic   collision;

    ////////////////////
    // Address decode
    ////////////////////

    always_comb begin
        wrEn = '0;
        wrData = '0;
        collision = 1'b0;
        stageWritten = 1'b0;
        for (int l = 0; l < `FFT_LANES; l++) begin
            if (res[l].valid) begin
                collision = collision || wrEn[res[l].addrA] || wrEn[res[l].addrB]
                            || res[l].addrA == res[l].addrB;
                wrEn[res[l].addrA] = 1'b1;
                wrEn[res[l].addrB] = 1'b1;
                wrData[res[l].addrA] = res[l].x;
                wrData[res[l].addrB] = res[l].y;
                stageWritten = 1'b1;
            end
        end
    end

    assign done = stageWritten && stagesDone == LastStage;

    // Finished stages of the current run
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stagesDone <= '0;
        end else if (stageWritten) begin
            stagesDone <= done ? '0 : stagesDone + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !collision)
        else $error("Two lanes write the same address");

    // Feeder and collector agree on the stage being retired
    assert property (@(posedge clk) disable iff (rst) stageWritten |-> stage == stagesDone)
        else $error("Stage count mismatch");

endmodule

/* logic/fftEngine.sv */
`timescale 1ns/1ns
`include "fft_consts.svh"

module fftEngine (
    input  logic            clk,
    input  logic            rst,
    input  logic            startF,
    input  logic            startI,
    input  logic            startLoadingRam,
    input  logic            transformComplete,
    input  logic            sampleValid,
    input  fftTypes::cplx_t sampleIn,
    output logic            outValid,
    output fftTypes::cplx_t outSample,
    output logic            calculating,
    output logic            aDone
);

    import fftTypes::*;

    logic loadExternal;
    logic loadInternal;
    logic isIFFT;
    logic loadOutBuffer;
    logic loadExternalDone;
    logic done;
    logic outDone;
    logic stageWritten;
    stage_t stage;
    logic [`FFT_POINTS-1:0] wrEn;
    cplx_t [`FFT_POINTS-1:0] words;
    cplx_t [`FFT_POINTS-1:0] wrData;
    bflyOp_t [`FFT_LANES-1:0] ops;
    bflyRes_t [`FFT_LANES-1:0] res;

    fftControl control0 (
        .clk(clk),
        .rst(rst),
        .startF(startF),
        .startI(startI),
        .startLoadingRam(startLoadingRam),
        .loadExternalDone(loadExternalDone),
        .done(done),
        .outDone(outDone),
        .transformComplete(transformComplete),
        .calculating(calculating),
        .loadExternal(loadExternal),
        .loadInternal(loadInternal),
        .isIFFT(isIFFT),
        .aDone(aDone),
        .loadOutBuffer(loadOutBuffer)
    );

    sampleRam ram0 (
        .clk(clk),
        .rst(rst),
        .loadExternal(loadExternal),
        .loadOutBuffer(loadOutBuffer),
        .sampleValid(sampleValid),
        .sampleIn(sampleIn),
        .wrEn(wrEn),
        .wrData(wrData),
        .loadExternalDone(loadExternalDone),
        .words(words),
        .outValid(outValid),
        .outSample(outSample),
        .outDone(outDone)
    );

    stageFeeder feeder0 (
        .clk(clk),
        .rst(rst),
        .loadInternal(loadInternal),
        .isIFFT(isIFFT),
        .stageWritten(stageWritten),
        .words(words),
        .ops(ops),
        .stage(stage)
    );

    // One butterfly per lane
    for (genvar l = 0; l < `FFT_LANES; l++) begin : gLane
        butterflyUnit bfly0 (
            .clk(clk),
            .rst(rst),
            .op(ops[l]),
            .res(res[l])
        );
    end

    stageCollector collector0 (
        .clk(clk),
        .rst(rst),
        .res(res),
        .stage(stage),
        .wrEn(wrEn),
        .wrData(wrData),
        .stageWritten(stageWritten),
        .done(done)
    );

endmodule

/* testbench/fftTb.sv */
`timescale 1ns/1ns
`include "fft_consts.svh"

module fftTb;

    import fftTypes::*;

    typedef cplx_t [`FFT_POINTS-1:0] frame_t;

    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 3;
    localparam int RunCount = 9;
    localparam int CyclesPerRun = 200;
    localparam real Pi = 3.14159265358979;

    logic   clk = 1'b0;
    logic   rst;
    logic   startF;
    logic   startI;
    logic   startLoadingRam;
    logic   transformComplete;
    logic   sampleValid;
    cplx_t  sampleIn;
    logic   outValid;
    cplx_t  outSample;
    logic   calculating;
    logic   aDone;

    logic [31:0] lcgState = 32'hf2e7_b521;
    frame_t expFrame;
    frame_t captured;
    int     outCount = 0;
    logic   outputsAllowed = 1'b0;

    fftEngine dut0 (
        .clk(clk),
        .rst(rst),
        .startF(startF),
        .startI(startI),
        .startLoadingRam(startLoadingRam),
        .transformComplete(transformComplete),
        .sampleValid(sampleValid),
        .sampleIn(sampleIn),
        .outValid(outValid),
        .outSample(outSample),
        .calculating(calculating),
        .aDone(aDone)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Parts stay within 15 bits so no butterfly can overflow
    function automatic frame_t randomFrame();
        frame_t f;
        logic [31:0] r;
        for (int i = 0; i < `FFT_POINTS; i++) begin
            r = nextRandom();
            f[i].re = sample_t'($signed(r[30:16]));
            r = nextRandom();
            f[i].im = sample_t'($signed(r[30:16]));
        end
        return f;
    endfunction

    function automatic longint roundHalfAway(input real x);
        if (x >= 0.0) begin
            return longint'($floor(x + 0.5));
        end else begin
            return -longint'($floor(-x + 0.5));
        end
    endfunction

    function automatic longint twiddleRe(input int k);
        return roundHalfAway((1 << `TWIDDLE_FRAC) * $cos(2.0 * Pi * k / `FFT_POINTS));
    endfunction

    function automatic longint twiddleIm(input int k);
        return -roundHalfAway((1 << `TWIDDLE_FRAC) * $sin(2.0 * Pi * k / `FFT_POINTS));
    endfunction

    function automatic longint wrapSample(input longint v);
        sample_t s;
        s = sample_t'(v);
        return longint'(s);
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic frame_t fftRef(input frame_t src, input logic inverse);
        longint re [`FFT_POINTS];
        longint im [`FFT_POINTS];
        frame_t dst;
        int     rev;
        int     span;
        int     ia;
        int     ib;
        int     k;
        longint wr;
        longint wi;
        longint tr;
        longint ti;
        longint ar;
        longint ai;
        for (int i = 0; i < `FFT_POINTS; i++) begin
            rev = 0;
            for (int b = 0; b < `FFT_STAGES; b++) begin
                if (((i >> b) & 1) != 0) begin
                    rev = rev | (1 << (`FFT_STAGES - 1 - b));
                end
            end
            re[rev] = longint'(src[i].re);
            im[rev] = longint'(src[i].im);
        end
        for (int s = 0; s < `FFT_STAGES; s++) begin
            span = 1 << s;
            for (int g = 0; g < `FFT_POINTS; g += 2 * span) begin
                for (int p = 0; p < span; p++) begin
                    ia = g + p;
                    ib = ia + span;
                    k = p * (`FFT_POINTS / 2) / span;
                    wr = twiddleRe(k);
                    wi = inverse ? -twiddleIm(k) : twiddleIm(k);
                    tr = (re[ib] * wr - im[ib] * wi) >>> `TWIDDLE_FRAC;
                    ti = (re[ib] * wi + im[ib] * wr) >>> `TWIDDLE_FRAC;
                    ar = re[ia];
                    ai = im[ia];
                    re[ia] = wrapSample((ar + tr) >>> 1);
                    im[ia] = wrapSample((ai + ti) >>> 1);
                    re[ib] = wrapSample((ar - tr) >>> 1);
                    im[ib] = wrapSample((ai - ti) >>> 1);
                end
            end
        end
        for (int i = 0; i < `FFT_POINTS; i++) begin
            dst[i].re = sample_t'(re[i]);
            dst[i].im = sample_t'(im[i]);
        end
        return dst;
    endfunction

    ////////////////////
    // One transform
    ////////////////////

    task automatic runTransform(input frame_t src, input frame_t expected,
                                input logic inverse, input logic withGaps,
                                input logic extraStart, output frame_t got);
        logic [31:0] r;
        expFrame = expected;
        outCount = 0;
        outputsAllowed = 1'b0;
        startF = !inverse;
        startI = inverse;
        @(negedge clk);
        startF = 1'b0;
        startI = 1'b0;
        checkValue("calculating after start", calculating, 1);
        startLoadingRam = 1'b1;
        @(negedge clk);
        startLoadingRam = 1'b0;
        for (int i = 0; i < `FFT_POINTS; i++) begin
            r = nextRandom();
            while (withGaps && r[31]) begin
                sampleValid = 1'b0;
                @(negedge clk);
                r = nextRandom();
            end
            sampleValid = 1'b1;
            sampleIn = src[i];
            // Stray start of the other direction mid-load
            if (extraStart && i == 2) begin
                startF = inverse;
                startI = !inverse;
            end
            @(negedge clk);
            startF = 1'b0;
            startI = 1'b0;
        end
        sampleValid = 1'b0;
        sampleIn = '0;
        // No output may appear during the stage computations
        repeat (`FFT_STAGES * 3) @(negedge clk);
        @(posedge clk);
        outputsAllowed = 1'b1;
        @(negedge clk);
        while (!aDone) begin
            @(negedge clk);
        end
        checkValue("output count at aDone", outCount, `FFT_POINTS);
        for (int i = 0; i < 3; i++) begin
            if (extraStart && i == 0) begin
                startF = inverse;
                startI = !inverse;
            end
            @(negedge clk);
            startF = 1'b0;
            startI = 1'b0;
            checkValue("aDone before transformComplete", aDone, 1);
        end
        transformComplete = 1'b1;
        @(negedge clk);
        transformComplete = 1'b0;
        checkValue("aDone after transformComplete", aDone, 0);
        checkValue("calculating after transformComplete", calculating, 0);
        outputsAllowed = 1'b0;
        got = captured;
    endtask

    // Output comparison
    always @(negedge clk) begin
        if (outValid) begin
            if (!outputsAllowed) begin
                abortRun("outValid was high before the stages could have finished");
            end else if (outCount >= `FFT_POINTS) begin
                abortRun("More than eight outValid pulses occurred in one run");
            end else begin
                checkValue($sformatf("outSample[%0d]", outCount), outSample,
                           expFrame[outCount]);
                captured[outCount] = outSample;
                outCount++;
            end
        end
    end

    // Watchdog
    initial begin
        #(ClkPeriod * (ResetCycles + RunCount * CyclesPerRun));
        abortRun($sformatf("Timeout after %0d cycles, the DUT never finished",
                           ResetCycles + RunCount * CyclesPerRun));
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        frame_t src;
        frame_t expected;
        frame_t first;
        frame_t second;
        cplx_t  imp;
        rst = 1'b1;
        startF = 1'b0;
        startI = 1'b0;
        startLoadingRam = 1'b0;
        transformComplete = 1'b0;
        sampleValid = 1'b0;
        sampleIn = '0;
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        checkValue("calculating after reset", calculating, 0);
        checkValue("aDone after reset", aDone, 0);
        checkValue("outValid after reset", outValid, 0);

        // Impulse at index 0 spreads evenly over all bins
        imp = '{re: 16'sh1235, im: -16'sh0457};
        src = '0;
        src[0] = imp;
        for (int i = 0; i < `FFT_POINTS; i++) begin
            expected[i].re = imp.re >>> 3;
            expected[i].im = imp.im >>> 3;
        end
        runTransform(src, expected, 1'b0, 1'b0, 1'b0, first);

        // Forward, then the same data loaded with gaps
        src = randomFrame();
        expected = fftRef(src, 1'b0);
        runTransform(src, expected, 1'b0, 1'b0, 1'b0, first);
        runTransform(src, expected, 1'b0, 1'b1, 1'b0, second);
        for (int i = 0; i < `FFT_POINTS; i++) begin
            checkValue($sformatf("gap-loaded outSample[%0d]", i), second[i], first[i]);
        end
        src = randomFrame();
        runTransform(src, fftRef(src, 1'b0), 1'b0, 1'b0, 1'b0, first);

        // Inverse runs
        src = randomFrame();
        expected = fftRef(src, 1'b1);
        runTransform(src, expected, 1'b1, 1'b0, 1'b0, first);
        runTransform(src, expected, 1'b1, 1'b1, 1'b0, second);
        for (int i = 0; i < `FFT_POINTS; i++) begin
            checkValue($sformatf("gap-loaded inverse outSample[%0d]", i), second[i], first[i]);
        end
        src = randomFrame();
        runTransform(src, fftRef(src, 1'b1), 1'b1, 1'b0, 1'b0, first);

        // Stray start pulses during a run
        src = randomFrame();
        runTransform(src, fftRef(src, 1'b0), 1'b0, 1'b0, 1'b1, first);
        src = randomFrame();
        runTransform(src, fftRef(src, 1'b1), 1'b1, 1'b1, 1'b1, first);

        repeat (2) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

/* fftEngine.f */
+incdir+common
common/fftTypes.sv
control/fftControl.sv
logic/sampleRam.sv
butterfly/stageFeeder.sv
butterfly/butterflyUnit.sv
butterfly/stageCollector.sv
logic/fftEngine.sv
testbench/fftTb.sv
